// File: common/dma_params.svh
/*
 widths for the dram dma engine, included by the package and by the rtl
 that sizes ports directly
*/
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// dram word address
`define DMA_ADDR_W 21

// dram word
`define DMA_DATA_W 16

// burst length and burst count
`define DMA_LEN_W 8

// cpu register strobes, launch strobe sits on top of these
`define DMA_PORT_W 8

`endif

// File: common/dma_pkg.sv
/*
 types shared by the dma blocks: vector widths, mode and phase encodings,
 the control byte and the bundles passed between blocks
*/
`include "dma_params.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_W-1:0] dram_addr_t;
  typedef logic [`DMA_DATA_W-1:0] word_t;
  typedef logic [`DMA_LEN_W-1:0]  cnt_t;

  typedef enum logic [1:0] {
    copy      = 2'd0,
    blit_mask = 2'd1,
    blit_add  = 2'd2,
    fill      = 2'd3
  } dma_mode_e;

  // one dram access per phase
  typedef enum logic [1:0] {
    rd_src = 2'd0,
    rd_dst = 2'd1,
    wr_dst = 2'd2
  } dma_phase_e;

  // control byte as written by the cpu
  typedef struct packed {
    logic      spare_h;
    logic      opt;      // saturate in add blit
    logic      salgn;
    logic      dalgn;
    logic      asz;      // byte units, 512-word lines
    logic      spare_l;
    dma_mode_e mode;
  } dma_ctrl_t;

  typedef struct packed {
    dma_ctrl_t  ctrl;
    dram_addr_t s_start;
    dram_addr_t d_start;
    cnt_t       b_len;    // words per burst minus one
    cnt_t       b_num;    // bursts minus one
  } dma_cfg_t;

  typedef struct packed {
    logic src_step;
    logic dst_step;
    logic burst_end;      // current word is the last one of its burst
  } dma_step_t;

endpackage

// File: dma/dma_regs.sv
/*
 cpu side register stage: one-hot byte strobes load addresses, length
 and count; the control strobe stores the control byte and starts a transfer
*/
`include "dma_params.svh"

module dma_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [7:0]           zdata,
  input  logic [`DMA_PORT_W:0] dmaport_wr,
  output dma_pkg::dma_cfg_t    cfg,
  output logic                 launch
);

  // strobe positions in dmaport_wr
  localparam int SADDRL = 0;
  localparam int SADDRH = 1;
  localparam int SADDRX = 2;
  localparam int DADDRL = 3;
  localparam int DADDRH = 4;
  localparam int DADDRX = 5;
  localparam int LEN    = 6;
  localparam int NUM    = 7;
  localparam int LAUNCH = 8;

  // top slice of the address above bit 15
  localparam int XW = `DMA_ADDR_W - 16;

  // configuration bytes
  always_ff @(posedge clk)
  begin
    if (dmaport_wr[SADDRL])
      cfg.s_start[7:0] <= zdata;
    if (dmaport_wr[SADDRH])
      cfg.s_start[15:8] <= zdata;
    if (dmaport_wr[SADDRX])
      cfg.s_start[`DMA_ADDR_W-1:16] <= zdata[XW-1:0];

    if (dmaport_wr[DADDRL])
      cfg.d_start[7:0] <= zdata;
    if (dmaport_wr[DADDRH])
      cfg.d_start[15:8] <= zdata;
    if (dmaport_wr[DADDRX])
      cfg.d_start[`DMA_ADDR_W-1:16] <= zdata[XW-1:0];

    if (dmaport_wr[LEN])
      cfg.b_len <= zdata;
    if (dmaport_wr[NUM])
      cfg.b_num <= zdata;

    if (dmaport_wr[LAUNCH])
      cfg.ctrl <= dma_pkg::dma_ctrl_t'(zdata);   // control write starts the dma
  end

  // single cycle start pulse alongside the new ctrl
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      launch <= 1'b0;
    else
      launch <= dmaport_wr[LAUNCH];
  end

endmodule

// File: dma/dma_sequencer.sv
/*
 access sequencer: walks the rd_src / rd_dst / wr_dst phases per mode,
 counts words and bursts, drives the dram request and the end interrupt
*/
`include "dma_params.svh"

module dma_sequencer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  dma_pkg::dma_cfg_t       cfg,
  input  logic                    launch,
  input  logic                    dram_next,
  output dma_pkg::dma_phase_e     phase,
  output dma_pkg::dma_step_t      step,
  output logic                    dram_req,
  output logic                    dram_rnw,
  output logic                    dma_act,
  output logic                    int_start
);

  logic [`DMA_LEN_W:0] n_ctr;      // burst counter, msb set when done
  dma_pkg::cnt_t       b_ctr;      // words left in burst minus one
  logic                act_q;
  logic                is_blit;
  logic                burst_last;
  logic                acc_done;
  logic                word_done;

  assign dma_act    = !n_ctr[`DMA_LEN_W];
  assign is_blit    = (cfg.ctrl.mode == dma_pkg::blit_mask) ||
                      (cfg.ctrl.mode == dma_pkg::blit_add);
  assign burst_last = (b_ctr == '0);
  assign acc_done   = dma_act && dram_next;   // current access accepted
  assign word_done  = acc_done && (phase == dma_pkg::wr_dst);

  // one access always pending while active
  assign dram_req = dma_act;
  assign dram_rnw = (phase != dma_pkg::wr_dst);

  assign step.src_step  = acc_done && (phase == dma_pkg::rd_src);
  assign step.dst_step  = word_done;
  assign step.burst_end = burst_last;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      phase <= dma_pkg::rd_src;
    else if (launch)
      phase <= dma_pkg::rd_src;
    else if (acc_done)
    begin
      case (phase)
        dma_pkg::rd_src:
          phase <= is_blit ? dma_pkg::rd_dst : dma_pkg::wr_dst;
        dma_pkg::rd_dst:
          phase <= dma_pkg::wr_dst;
        default:
          // fill keeps writing the one word it read
          phase <= (cfg.ctrl.mode == dma_pkg::fill) ? dma_pkg::wr_dst : dma_pkg::rd_src;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      n_ctr <= {1'b1, {`DMA_LEN_W{1'b0}}};
      b_ctr <= '0;
    end
    else if (launch)
    begin
      n_ctr <= {1'b0, cfg.b_num};
      b_ctr <= cfg.b_len;
    end
    else if (word_done)
    begin
      b_ctr <= burst_last ? cfg.b_len : b_ctr - 1'b1;
      n_ctr <= n_ctr - {{`DMA_LEN_W{1'b0}}, burst_last};  // underflow ends transfer
    end
  end

  // interrupt on falling edge of activity
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      act_q <= 1'b0;
    else
      act_q <= dma_act;
  end

  assign int_start = act_q && !dma_act;

endmodule

// File: dma/dma_addr_gen.sv
/*
 source and destination address counters; linear or aligned stepping,
 aligned wraps back to the start low byte one line down at burst end
*/
`include "dma_params.svh"

module dma_addr_gen (
  input  logic                clk,
  input  dma_pkg::dma_cfg_t   cfg,
  input  logic                launch,
  input  dma_pkg::dma_step_t  step,
  output dma_pkg::dram_addr_t s_addr,
  output dma_pkg::dram_addr_t d_addr
);

  localparam dma_pkg::dram_addr_t LINE_256 = 256;
  localparam dma_pkg::dram_addr_t LINE_512 = 512;

  logic [7:0]          s_low;    // start low bytes for aligned wrap
  logic [7:0]          d_low;
  dma_pkg::dram_addr_t s_next;
  dma_pkg::dram_addr_t d_next;

  function automatic dma_pkg::dram_addr_t addr_next(
    input dma_pkg::dram_addr_t addr,
    input logic [7:0]          low,
    input logic                algn,
    input logic                asz,
    input logic                burst_end
  );
    dma_pkg::dram_addr_t line_base;
    line_base = {addr[`DMA_ADDR_W-1:8], 8'h00} + (asz ? LINE_512 : LINE_256);
    if (algn && burst_end)
      return {line_base[`DMA_ADDR_W-1:8], low};   // next line, same column
    else
      return addr + 1'b1;
  endfunction

  assign s_next = addr_next(s_addr, s_low, cfg.ctrl.salgn, cfg.ctrl.asz, step.burst_end);
  assign d_next = addr_next(d_addr, d_low, cfg.ctrl.dalgn, cfg.ctrl.asz, step.burst_end);

  always_ff @(posedge clk)
  begin
    if (launch)
    begin
      s_addr <= cfg.s_start;
      d_addr <= cfg.d_start;
      s_low  <= cfg.s_start[7:0];
      d_low  <= cfg.d_start[7:0];
    end
    else
    begin
      if (step.src_step)
        s_addr <= s_next;
      if (step.dst_step)
        d_addr <= d_next;
    end
  end

endmodule

// File: dma/dma_datapath.sv
/*
 data register between read and write; in blit modes the destination
 read merges into it by transparency mask or per-unit add
*/
`include "dma_params.svh"

module dma_datapath (
  input  logic                clk,
  input  dma_pkg::dma_cfg_t   cfg,
  input  dma_pkg::dma_phase_e phase,
  input  logic                dram_next,
  input  dma_pkg::word_t      dram_rddata,
  output dma_pkg::word_t      dram_wrdata
);

  dma_pkg::word_t data_q;
  dma_pkg::word_t blit_res;

  function automatic dma_pkg::word_t blit_combine(
    input dma_pkg::word_t src,
    input dma_pkg::word_t dst,
    input logic           byte_unit,
    input logic           add_mode,
    input logic           sat
  );
    dma_pkg::word_t res_n;
    dma_pkg::word_t res_b;
    logic [4:0]     sum_n;
    logic [8:0]     sum_b;
    for (int i = 0; i < `DMA_DATA_W / 4; i++)
    begin
      sum_n = {1'b0, src[i*4 +: 4]} + {1'b0, dst[i*4 +: 4]};
      if (!add_mode)
        res_n[i*4 +: 4] = (|src[i*4 +: 4]) ? src[i*4 +: 4] : dst[i*4 +: 4];
      else if (sat && sum_n[4])
        res_n[i*4 +: 4] = 4'hf;   // clip to all ones
      else
        res_n[i*4 +: 4] = sum_n[3:0];
    end
    for (int j = 0; j < `DMA_DATA_W / 8; j++)
    begin
      sum_b = {1'b0, src[j*8 +: 8]} + {1'b0, dst[j*8 +: 8]};
      if (!add_mode)
        res_b[j*8 +: 8] = (|src[j*8 +: 8]) ? src[j*8 +: 8] : dst[j*8 +: 8];
      else if (sat && sum_b[8])
        res_b[j*8 +: 8] = 8'hff;
      else
        res_b[j*8 +: 8] = sum_b[7:0];
    end
    return byte_unit ? res_b : res_n;
  endfunction

  assign blit_res = blit_combine(data_q, dram_rddata, cfg.ctrl.asz,
                                 cfg.ctrl.mode == dma_pkg::blit_add, cfg.ctrl.opt);

  always_ff @(posedge clk)
  begin
    if (dram_next && (phase == dma_pkg::rd_src))
      data_q <= dram_rddata;            // source word
    else if (dram_next && (phase == dma_pkg::rd_dst))
      data_q <= blit_res;               // merged with destination
  end

  assign dram_wrdata = data_q;

endmodule

// File: verilog/dma_top.sv
/*
 dram to dram dma engine top: register stage, sequencer, address
 generator and data path; the dram address follows the current phase
*/
`include "dma_params.svh"

module dma_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [7:0]           zdata,
  input  logic [`DMA_PORT_W:0] dmaport_wr,
  output dma_pkg::dram_addr_t  dram_addr,
  input  dma_pkg::word_t       dram_rddata,
  output dma_pkg::word_t       dram_wrdata,
  output logic                 dram_req,
  output logic                 dram_rnw,
  input  logic                 dram_next,
  output logic                 dma_act,
  output logic                 int_start
);

  dma_pkg::dma_cfg_t   cfg;
  dma_pkg::dma_step_t  step;
  dma_pkg::dma_phase_e phase;
  dma_pkg::dram_addr_t s_addr;
  dma_pkg::dram_addr_t d_addr;
  logic                launch;

  dma_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .zdata      (zdata),
    .dmaport_wr (dmaport_wr),
    .cfg        (cfg),
    .launch     (launch)
  );

  dma_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .launch    (launch),
    .dram_next (dram_next),
    .phase     (phase),
    .step      (step),
    .dram_req  (dram_req),
    .dram_rnw  (dram_rnw),
    .dma_act   (dma_act),
    .int_start (int_start)
  );

  dma_addr_gen u_addr (
    .clk    (clk),
    .cfg    (cfg),
    .launch (launch),
    .step   (step),
    .s_addr (s_addr),
    .d_addr (d_addr)
  );

  dma_datapath u_data (
    .clk         (clk),
    .cfg         (cfg),
    .phase       (phase),
    .dram_next   (dram_next),
    .dram_rddata (dram_rddata),
    .dram_wrdata (dram_wrdata)
  );

  // source only while reading it
  assign dram_addr = (phase == dma_pkg::rd_src) ? s_addr : d_addr;

endmodule

// File: tb/dram_model.sv
/*
 testbench dram: word array preloaded with random data, answers each
 request after a random wait of 0 to 3 cycles
*/
`include "dma_params.svh"

module dram_model #(
  parameter int MEM_AW = 12
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                dram_req,
  input  logic                dram_rnw,
  input  dma_pkg::dram_addr_t dram_addr,
  input  dma_pkg::word_t      dram_wrdata,
  output dma_pkg::word_t      dram_rddata,
  output logic                dram_next
);

  dma_pkg::word_t mem [0:(1 << MEM_AW) - 1];
  integer         seed;
  logic           next_q;
  logic [1:0]     wait_left;   // low cycles left before the pulse
  logic [1:0]     delay;

  initial
  begin
    seed = 90336;
    for (int i = 0; i < (1 << MEM_AW); i++)
      mem[i] = $random(seed);
  end

  // no pulse without a request
  assign dram_next   = next_q && dram_req;
  assign dram_rddata = mem[dram_addr[MEM_AW-1:0]];

  always @(posedge clk)
  begin
    if (!rst_n || !dram_req)
    begin
      next_q    <= 1'b0;
      wait_left <= 2'd0;
    end
    else if (next_q)
    begin
      if (!dram_rnw)
        mem[dram_addr[MEM_AW-1:0]] <= dram_wrdata;
      delay = $random(seed);
      next_q    <= (delay == 2'd0);   // back to back access
      wait_left <= delay - 2'd1;
    end
    else if (wait_left == 2'd0)
      next_q <= 1'b1;
    else
      wait_left <= wait_left - 2'd1;
  end

endmodule

// File: tb/tb_dma.sv
/*
 testbench for the dma engine: programs the cpu registers, runs copy,
 blit and fill transfers against the dram model and checks the memory image
*/
`include "dma_params.svh"

module tb_dma;

  localparam int MEM_WORDS   = 4096;
  // copy 15, two aligned copies of 12, six blits of 16, fill 20
  localparam int TOTAL_WORDS = 15 + 2 * 12 + 6 * 16 + 20;
  localparam int CYCLE_LIMIT = 3 * 4 * TOTAL_WORDS + 200;

  logic                 clk;
  logic                 rst_n;
  logic [7:0]           zdata;
  logic [`DMA_PORT_W:0] dmaport_wr;
  dma_pkg::dram_addr_t  dram_addr;
  dma_pkg::word_t       dram_rddata;
  dma_pkg::word_t       dram_wrdata;
  logic                 dram_req;
  logic                 dram_rnw;
  logic                 dram_next;
  logic                 dma_act;
  logic                 int_start;

  dma_pkg::word_t snap    [0:MEM_WORDS-1];
  dma_pkg::word_t exp_img [0:MEM_WORDS-1];
  string          test_name = "reset";
  int             cycles = 0;
  int             int_pulses = 0;
  int             rd_accesses = 0;
  int             wr_accesses = 0;
  int             checks_done = 0;
  int             tests_run = 0;

  dma_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .zdata       (zdata),
    .dmaport_wr  (dmaport_wr),
    .dram_addr   (dram_addr),
    .dram_rddata (dram_rddata),
    .dram_wrdata (dram_wrdata),
    .dram_req    (dram_req),
    .dram_rnw    (dram_rnw),
    .dram_next   (dram_next),
    .dma_act     (dma_act),
    .int_start   (int_start)
  );

  dram_model mem0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .dram_req    (dram_req),
    .dram_rnw    (dram_rnw),
    .dram_addr   (dram_addr),
    .dram_wrdata (dram_wrdata),
    .dram_rddata (dram_rddata),
    .dram_next   (dram_next)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  function automatic logic [7:0] ctrl_byte(input dma_pkg::dma_mode_e mode, input logic opt,
                                           input logic salgn, input logic dalgn,
                                           input logic asz);
    return {1'b0, opt, salgn, dalgn, asz, 1'b0, mode};
  endfunction

  // one address step, aligned ones jump a line at the end of a burst
  function automatic dma_pkg::dram_addr_t next_addr(input dma_pkg::dram_addr_t addr,
                                                    input logic [7:0] low, input logic aligned,
                                                    input logic big_line, input logic last);
    dma_pkg::dram_addr_t line;
    line = big_line ? 512 : 256;
    if (aligned && last)
      return (((addr >> 8) << 8) + line) | low;
    return addr + 1;
  endfunction

  // per-unit mask or add of source over destination
  function automatic dma_pkg::word_t unit_combine(input dma_pkg::word_t s, input dma_pkg::word_t d,
                                                  input logic add, input logic byte_unit,
                                                  input logic sat);
    int             u;
    int             top;
    int             sv;
    int             dv;
    int             r;
    dma_pkg::word_t res;
    u   = byte_unit ? 8 : 4;
    top = (1 << u) - 1;
    res = '0;
    for (int k = 0; k < 16; k += u)
    begin
      sv = (s >> k) & top;
      dv = (d >> k) & top;
      if (!add)
        r = (sv != 0) ? sv : dv;   // zero unit is transparent
      else
      begin
        r = sv + dv;
        if (r > top)
          r = sat ? top : r - (top + 1);
      end
      res = res | (r << k);
    end
    return res;
  endfunction

  // walks the transfer over the snapshot into exp_img
  function automatic void build_expected(input logic [7:0] ctrl,
                                         input dma_pkg::dram_addr_t s_start,
                                         input dma_pkg::dram_addr_t d_start,
                                         input int len, input int num);
    dma_pkg::dram_addr_t sa;
    dma_pkg::dram_addr_t da;
    dma_pkg::word_t      data;
    logic [1:0]          mode;
    mode = ctrl[1:0];
    sa   = s_start;
    da   = d_start;
    for (int i = 0; i < MEM_WORDS; i++)
      exp_img[i] = snap[i];
    data = exp_img[sa[11:0]];   // the single fill read
    for (int b = 0; b <= num; b++)
      for (int w = 0; w <= len; w++)
      begin
        if (mode != dma_pkg::fill)
        begin
          data = exp_img[sa[11:0]];
          if (mode != dma_pkg::copy)
            data = unit_combine(data, exp_img[da[11:0]], mode == dma_pkg::blit_add,
                                ctrl[3], ctrl[6]);
          sa = next_addr(sa, s_start[7:0], ctrl[5], ctrl[3], w == len);
        end
        exp_img[da[11:0]] = data;
        da = next_addr(da, d_start[7:0], ctrl[4], ctrl[3], w == len);
      end
  endfunction

  task automatic compare_image();
    for (int i = 0; i < MEM_WORDS; i++)
      compare_value($sformatf("%s word %03h", test_name, i), exp_img[i], mem0.mem[i]);
  endtask

  // zero bytes and nibbles so mask blits see transparent units
  task automatic thin_source(input int base, input int n);
    for (int i = 0; i < n; i++)
      mem0.mem[base + i] = mem0.mem[base + i] & ((i % 3 == 0) ? 16'hff00 :
                                                  (i % 3 == 1) ? 16'h0f0f : 16'hffff);
  endtask

  task automatic write_reg(input int port, input logic [7:0] value);
    logic [`DMA_PORT_W:0] strobe;
    strobe       = '0;
    strobe[port] = 1'b1;
    @(posedge clk);
    dmaport_wr <= strobe;
    zdata      <= value;
  endtask

  task automatic run_test(input string name, input logic [7:0] ctrl,
                          input dma_pkg::dram_addr_t s_start,
                          input dma_pkg::dram_addr_t d_start, input int len, input int num);
    int rd_before;
    int wr_before;
    int words;
    int exp_reads;
    words = (len + 1) * (num + 1);
    case (ctrl[1:0])
      dma_pkg::copy: exp_reads = words;
      dma_pkg::fill: exp_reads = 1;
      default:       exp_reads = 2 * words;   // source and destination
    endcase
    test_name = name;
    @(negedge clk);
    for (int i = 0; i < MEM_WORDS; i++)
      snap[i] = mem0.mem[i];
    build_expected(ctrl, s_start, d_start, len, num);
    rd_before = rd_accesses;
    wr_before = wr_accesses;
    write_reg(0, s_start[7:0]);
    write_reg(1, s_start[15:8]);
    write_reg(2, {3'b000, s_start[20:16]});
    write_reg(3, d_start[7:0]);
    write_reg(4, d_start[15:8]);
    write_reg(5, {3'b000, d_start[20:16]});
    write_reg(6, len);
    write_reg(7, num);
    write_reg(8, ctrl);
    @(posedge clk);
    dmaport_wr <= '0;
    @(negedge clk);
    compare_value({name, " req at launch"}, 0, dram_req);
    @(negedge clk);
    compare_value({name, " req after launch"}, 1, dram_req);
    tests_run = tests_run + 1;
    while (checks_done < tests_run)
      @(negedge clk);
    repeat (2) @(negedge clk);
    compare_value({name, " irq cycles"}, tests_run, int_pulses);
    compare_value({name, " reads"}, exp_reads, rd_accesses - rd_before);
    compare_value({name, " writes"}, words, wr_accesses - wr_before);
  endtask

  // timeout, access counts, address range
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("Test failed");
      $fatal(1, "timeout, the transfers did not finish within %0d cycles", CYCLE_LIMIT);
    end
    if (dram_req === 1'b1 && dram_next === 1'b1)
    begin
      compare_value({test_name, " address range"}, 0, dram_addr >> 12);
      if (dram_rnw)
        rd_accesses <= rd_accesses + 1;
      else
        wr_accesses <= wr_accesses + 1;
    end
  end

  // compare process on each interrupt cycle
  always @(negedge clk)
  begin
    if (int_start === 1'b1)
    begin
      int_pulses = int_pulses + 1;
      compare_value({test_name, " act at irq"}, 0, dma_act);
      compare_image();
      checks_done = checks_done + 1;
    end
  end

  initial
  begin
    rst_n      = 1'b0;
    zdata      = '0;
    dmaport_wr = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_value("reset act", 0, dma_act);
    compare_value("reset req", 0, dram_req);
    compare_value("reset irq", 0, int_start);

    run_test("copy_linear", ctrl_byte(dma_pkg::copy, 0, 0, 0, 0), 21'h010, 21'h800, 4, 2);
    run_test("copy_align_256", ctrl_byte(dma_pkg::copy, 0, 0, 1, 0), 21'h040, 21'h210, 3, 2);
    run_test("copy_align_512", ctrl_byte(dma_pkg::copy, 0, 1, 1, 1), 21'h058, 21'h620, 3, 2);
    thin_source(16'h100, 16);
    run_test("mask_nibble", ctrl_byte(dma_pkg::blit_mask, 0, 0, 0, 0), 21'h100, 21'hb00, 7, 1);
    thin_source(16'h120, 16);
    run_test("mask_byte", ctrl_byte(dma_pkg::blit_mask, 0, 0, 0, 1), 21'h120, 21'hb20, 7, 1);
    run_test("add_wrap_nibble", ctrl_byte(dma_pkg::blit_add, 0, 0, 0, 0), 21'h140, 21'hb40, 7, 1);
    run_test("add_sat_nibble", ctrl_byte(dma_pkg::blit_add, 1, 0, 0, 0), 21'h160, 21'hb60, 7, 1);
    run_test("add_wrap_byte", ctrl_byte(dma_pkg::blit_add, 0, 0, 0, 1), 21'h180, 21'hb80, 7, 1);
    run_test("add_sat_byte", ctrl_byte(dma_pkg::blit_add, 1, 0, 0, 1), 21'h1a0, 21'hba0, 7, 1);
    run_test("fill", ctrl_byte(dma_pkg::fill, 0, 0, 0, 0), 21'h1c0, 21'hc00, 9, 1);

    $display("Test passed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+common
common/dma_pkg.sv
dma/dma_regs.sv
dma/dma_sequencer.sv
dma/dma_addr_gen.sv
dma/dma_datapath.sv
verilog/dma_top.sv
tb/dram_model.sv
tb/tb_dma.sv
